// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int WORD_W     = 32;    // data path
	localparam int REG_ADDR_W = 5;     // 32 general registers
	localparam int OP_W       = 5;
	localparam int EXC_W      = 5;     // cause register code field

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [2*WORD_W-1:0]   dword_t;     // full product, {hi, lo}
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	//////////////////////////////
	// operation codes
	//////////////////////////////
	// immediate forms share the register codes
	// decode puts the immediate into an operand
	typedef enum logic [OP_W-1:0] {
		OP_NOP   = 5'd0,
		// logic group
		OP_AND   = 5'd1,
		OP_OR    = 5'd2,
		OP_XOR   = 5'd3,
		OP_NOR   = 5'd4,
		OP_LUI   = 5'd5,     // immediate arrives in operand a
		// shift group
		OP_SLL   = 5'd6,
		OP_SRL   = 5'd7,
		OP_SRA   = 5'd8,
		// arithmetic group
		OP_ADD   = 5'd9,     // traps on overflow
		OP_ADDU  = 5'd10,
		OP_SUB   = 5'd11,    // traps on overflow
		OP_SUBU  = 5'd12,
		OP_SLT   = 5'd13,
		OP_SLTU  = 5'd14,
		OP_MULT  = 5'd15,
		OP_MULTU = 5'd16,
		// move group
		OP_MFHI  = 5'd17,
		OP_MFLO  = 5'd18,
		OP_MTHI  = 5'd19,
		OP_MTLO  = 5'd20
	} aluop_e;

	// exception codes, cause register encoding
	typedef enum logic [EXC_W-1:0] {
		EC_NONE = 5'h00,
		EC_OV   = 5'h0c     // integer overflow
	} exc_code_e;

endpackage

`default_nettype wire

// File: ex_pipe_pkg.sv
`default_nettype none

package ex_pipe_pkg;

	//////////////////////////////
	// pipeline structure
	//////////////////////////////
	// result buffer depth when the top level does not override it
	// must be a power of two, at least 2
	localparam int FIFO_DEPTH_DEF = 4;

	// overflow event counter
	localparam int EXC_CNT_W = 16;    // saturates, never wraps

	typedef logic [EXC_CNT_W-1:0] exc_cnt_t;

endpackage

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
	input  wire                          clk,
	input  wire                          rst_n_i,

	// decoded operation
	input  wire                          in_valid_i,
	input  wire mips_isa_pkg::aluop_e    in_op_i,
	input  wire mips_isa_pkg::word_t     in_a_i,       // reg1, or immediate for lui
	input  wire mips_isa_pkg::word_t     in_b_i,       // reg2 or immediate
	input  wire mips_isa_pkg::reg_addr_t in_wd_i,
	input  wire                          in_wreg_i,
	output logic                         in_ready_o,

	// push into result buffer
	output logic                         push_valid_o,
	input  wire                          push_ready_i,
	output mips_isa_pkg::word_t          push_wdata_o,
	output mips_isa_pkg::reg_addr_t      push_wd_o,
	output logic                         push_wreg_o,
	output logic                         push_ov_o
);
	import mips_isa_pkg::*;

	localparam int HALF_W  = WORD_W / 2;
	localparam int SHAMT_W = $clog2(WORD_W);

	word_t             hi_q;
	word_t             lo_q;
	word_t             logic_out;
	word_t             shift_out;
	word_t             arith_out;
	word_t             move_out;
	dword_t            prod_s;
	dword_t            prod_u;
	logic [WORD_W:0]   add_ext;      // one extra sign bit
	logic [WORD_W:0]   sub_ext;
	logic [SHAMT_W-1:0] shamt;
	logic              ov_add;
	logic              ov_sub;
	logic              accept;

	// no buffering here, ready comes straight from the fifo
	assign in_ready_o   = push_ready_i;
	assign push_valid_o = in_valid_i;
	assign accept       = in_valid_i && push_ready_i;

	assign shamt = in_b_i[SHAMT_W-1:0];   // low five bits only

	//////////////////////////////
	// logic group
	//////////////////////////////
	always_comb begin
		case (in_op_i)
			OP_AND:  logic_out = in_a_i & in_b_i;
			OP_OR:   logic_out = in_a_i | in_b_i;
			OP_XOR:  logic_out = in_a_i ^ in_b_i;
			OP_NOR:  logic_out = ~(in_a_i | in_b_i);
			OP_LUI:  logic_out = {in_a_i[HALF_W-1:0], {HALF_W{1'b0}}};
			default: logic_out = '0;
		endcase
	end

	//////////////////////////////
	// shift group
	//////////////////////////////
	always_comb begin
		case (in_op_i)
			OP_SLL:  shift_out = in_a_i << shamt;
			OP_SRL:  shift_out = in_a_i >> shamt;
			OP_SRA:  shift_out = word_t'($signed(in_a_i) >>> shamt);  // sign fill
			default: shift_out = '0;
		endcase
	end

	//////////////////////////////
	// arithmetic group
	//////////////////////////////
	assign add_ext = {in_a_i[WORD_W-1], in_a_i} + {in_b_i[WORD_W-1], in_b_i};
	assign sub_ext = {in_a_i[WORD_W-1], in_a_i} - {in_b_i[WORD_W-1], in_b_i};

	// top two bits disagree -> result left the signed range
	assign ov_add = add_ext[WORD_W] ^ add_ext[WORD_W-1];
	assign ov_sub = sub_ext[WORD_W] ^ sub_ext[WORD_W-1];

	// both products built at full width
	// kept apart so the signed one is not forced unsigned
	assign prod_s = $signed(in_a_i) * $signed(in_b_i);
	assign prod_u = in_a_i * in_b_i;

	always_comb begin
		case (in_op_i)
			OP_ADD, OP_ADDU: arith_out = add_ext[WORD_W-1:0];   // add wraps, commit drops it on ov
			OP_SUB, OP_SUBU: arith_out = sub_ext[WORD_W-1:0];
			OP_SLT:  arith_out = {{(WORD_W-1){1'b0}}, $signed(in_a_i) < $signed(in_b_i)};
			OP_SLTU: arith_out = {{(WORD_W-1){1'b0}}, in_a_i < in_b_i};
			default: arith_out = '0;     // mult/multu only touch hi/lo
		endcase
	end

	//////////////////////////////
	// move group and hi/lo
	//////////////////////////////
	always_comb begin
		case (in_op_i)
			OP_MFHI: move_out = hi_q;
			OP_MFLO: move_out = lo_q;
			default: move_out = '0;      // mthi/mtlo write no gpr data
		endcase
	end

	// hi/lo live here, updated in program order at the accepting edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (accept) begin
			case (in_op_i)
				OP_MULT:  {hi_q, lo_q} <= prod_s;
				OP_MULTU: {hi_q, lo_q} <= prod_u;
				OP_MTHI:  hi_q <= in_a_i;     // lo untouched
				OP_MTLO:  lo_q <= in_a_i;     // hi untouched
				default: begin
					hi_q <= hi_q;
					lo_q <= lo_q;
				end
			endcase
		end
	end

	// one group at most is nonzero for any op
	assign push_wdata_o = logic_out | shift_out | arith_out | move_out;
	assign push_wd_o    = in_wd_i;
	assign push_wreg_o  = in_wreg_i;
	assign push_ov_o    = ((in_op_i == OP_ADD) && ov_add) || ((in_op_i == OP_SUB) && ov_sub);

	// a push refused by the fifo stays offered, unchanged, until taken
	a_push_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		push_valid_o && !push_ready_i |=>
			push_valid_o && $stable(push_wdata_o) && $stable(push_wd_o)
			&& $stable(push_wreg_o) && $stable(push_ov_o));

endmodule

`default_nettype wire

// File: ex_result_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module ex_result_fifo #(
	parameter int DEPTH = ex_pipe_pkg::FIFO_DEPTH_DEF    // power of two, >= 2
) (
	input  wire                          clk,
	input  wire                          rst_n_i,

	// write side, from alu
	input  wire                          push_valid_i,
	input  wire mips_isa_pkg::word_t     push_wdata_i,
	input  wire mips_isa_pkg::reg_addr_t push_wd_i,
	input  wire                          push_wreg_i,
	input  wire                          push_ov_i,
	output logic                         push_ready_o,

	// read side, to commit
	output logic                         pop_valid_o,
	input  wire                          pop_ready_i,
	output mips_isa_pkg::word_t          pop_wdata_o,
	output mips_isa_pkg::reg_addr_t      pop_wd_o,
	output logic                         pop_wreg_o,
	output logic                         pop_ov_o
);
	import mips_isa_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);   // must hold DEPTH itself

	// entry storage
	word_t            wdata_mem [DEPTH];
	reg_addr_t        wd_mem    [DEPTH];
	logic             wreg_mem  [DEPTH];
	logic             ov_mem    [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;    // entries held
	logic             do_push;
	logic             do_pop;

	assign push_ready_o = (count != CNT_W'(DEPTH));   // not full
	assign pop_valid_o  = (count != '0);              // not empty

	assign do_push = push_valid_i && push_ready_o;
	assign do_pop  = pop_valid_o && pop_ready_i;

	//////////////////////////////
	// pointers and fill level
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

	// write at the push edge
	always_ff @(posedge clk) begin
		if (do_push) begin
			wdata_mem[wr_ptr] <= push_wdata_i;
			wd_mem[wr_ptr]    <= push_wd_i;
			wreg_mem[wr_ptr]  <= push_wreg_i;
			ov_mem[wr_ptr]    <= push_ov_i;
		end
	end

	// oldest entry always on the read port
	assign pop_wdata_o = wdata_mem[rd_ptr];
	assign pop_wd_o    = wd_mem[rd_ptr];
	assign pop_wreg_o  = wreg_mem[rd_ptr];
	assign pop_ov_o    = ov_mem[rd_ptr];

	// fill level bounded and in step with the pointer distance
	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
		(count <= CNT_W'(DEPTH))
		&& (PTR_W'(wr_ptr - rd_ptr) == count[PTR_W-1:0]));

endmodule

`default_nettype wire

// File: ex_commit.sv
`timescale 1ns/10ps
`default_nettype none

module ex_commit (
	input  wire                          clk,
	input  wire                          rst_n_i,

	// from result fifo
	input  wire                          pop_valid_i,
	input  wire mips_isa_pkg::word_t     pop_wdata_i,
	input  wire mips_isa_pkg::reg_addr_t pop_wd_i,
	input  wire                          pop_wreg_i,
	input  wire                          pop_ov_i,
	output logic                         pop_ready_o,

	// registered result
	output logic                         out_valid_o,
	input  wire                          out_ready_i,
	output mips_isa_pkg::reg_addr_t      out_wd_o,
	output logic                         out_wreg_o,
	output mips_isa_pkg::word_t          out_wdata_o,
	output mips_isa_pkg::exc_code_e      out_exc_o,
	output ex_pipe_pkg::exc_cnt_t        exc_cnt_o      // delivered overflows
);
	import mips_isa_pkg::*;
	import ex_pipe_pkg::*;

	localparam exc_cnt_t CNT_MAX = '1;

	logic load;     // take a new entry
	logic drain;    // current word leaves

	// take the next entry when empty or emptying this cycle
	assign pop_ready_o = !out_valid_o || out_ready_i;
	assign load        = pop_valid_i && pop_ready_o;
	assign drain       = out_valid_o && out_ready_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			out_valid_o <= 1'b0;
		else if (load)
			out_valid_o <= 1'b1;
		else if (drain)
			out_valid_o <= 1'b0;
	end

	//////////////////////////////
	// exception rule
	//////////////////////////////
	// overflow kills the register write and its data
	always_ff @(posedge clk) begin
		if (load) begin
			out_wd_o    <= pop_wd_i;
			out_wreg_o  <= pop_wreg_i && !pop_ov_i;
			out_wdata_o <= pop_ov_i ? '0 : pop_wdata_i;
			out_exc_o   <= pop_ov_i ? EC_OV : EC_NONE;
		end
	end

	// count only what actually left, stop at the top
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			exc_cnt_o <= '0;
		else if (drain && (out_exc_o == EC_OV) && (exc_cnt_o != CNT_MAX))
			exc_cnt_o <= exc_cnt_o + 1'b1;
	end

	// stalled output word is held until the sink takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=>
			out_valid_o && $stable(out_wdata_o) && $stable(out_wd_o)
			&& $stable(out_wreg_o) && $stable(out_exc_o));

endmodule

`default_nettype wire

// File: ex_unit.sv
`timescale 1ns/10ps
`default_nettype none

module ex_unit #(
	parameter int DEPTH = ex_pipe_pkg::FIFO_DEPTH_DEF
) (
	input  wire                          clk,
	input  wire                          rst_n_i,

	// operation stream in
	input  wire                          in_valid_i,
	input  wire mips_isa_pkg::aluop_e    in_op_i,
	input  wire mips_isa_pkg::word_t     in_a_i,
	input  wire mips_isa_pkg::word_t     in_b_i,
	input  wire mips_isa_pkg::reg_addr_t in_wd_i,
	input  wire                          in_wreg_i,
	output logic                         in_ready_o,

	// result stream out
	output logic                         out_valid_o,
	input  wire                          out_ready_i,
	output mips_isa_pkg::reg_addr_t      out_wd_o,
	output logic                         out_wreg_o,
	output mips_isa_pkg::word_t          out_wdata_o,
	output mips_isa_pkg::exc_code_e      out_exc_o,
	output ex_pipe_pkg::exc_cnt_t        exc_cnt_o
);
	import mips_isa_pkg::*;

	// alu -> fifo
	logic      push_valid;
	logic      push_ready;
	word_t     push_wdata;
	reg_addr_t push_wd;
	logic      push_wreg;
	logic      push_ov;

	// fifo -> commit
	logic      pop_valid;
	logic      pop_ready;
	word_t     pop_wdata;
	reg_addr_t pop_wd;
	logic      pop_wreg;
	logic      pop_ov;

	ex_alu ex_alu_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.in_op_i      (in_op_i),
		.in_a_i       (in_a_i),
		.in_b_i       (in_b_i),
		.in_wd_i      (in_wd_i),
		.in_wreg_i    (in_wreg_i),
		.in_ready_o   (in_ready_o),
		.push_valid_o (push_valid),
		.push_ready_i (push_ready),
		.push_wdata_o (push_wdata),
		.push_wd_o    (push_wd),
		.push_wreg_o  (push_wreg),
		.push_ov_o    (push_ov)
	);

	ex_result_fifo #(
		.DEPTH (DEPTH)
	) ex_result_fifo_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.push_valid_i (push_valid),
		.push_wdata_i (push_wdata),
		.push_wd_i    (push_wd),
		.push_wreg_i  (push_wreg),
		.push_ov_i    (push_ov),
		.push_ready_o (push_ready),
		.pop_valid_o  (pop_valid),
		.pop_ready_i  (pop_ready),
		.pop_wdata_o  (pop_wdata),
		.pop_wd_o     (pop_wd),
		.pop_wreg_o   (pop_wreg),
		.pop_ov_o     (pop_ov)
	);

	ex_commit ex_commit_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.pop_valid_i  (pop_valid),
		.pop_wdata_i  (pop_wdata),
		.pop_wd_i     (pop_wd),
		.pop_wreg_i   (pop_wreg),
		.pop_ov_i     (pop_ov),
		.pop_ready_o  (pop_ready),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_wd_o     (out_wd_o),
		.out_wreg_o   (out_wreg_o),
		.out_wdata_o  (out_wdata_o),
		.out_exc_o    (out_exc_o),
		.exc_cnt_o    (exc_cnt_o)
	);

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_PERIOD = 5,    // 10 ns clock
	parameter int RST_CYCLES  = 8
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// reset low for RST_CYCLES rising edges, released on an edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_ex_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_unit;
	import mips_isa_pkg::*;
	import ex_pipe_pkg::*;

	localparam int DEPTH      = FIFO_DEPTH_DEF;
	localparam int WAIT_LIMIT = 500;    // cycles before any wait gives up

	// one stimulus row with its expected result
	typedef struct {
		aluop_e    op;
		word_t     a;
		word_t     b;
		reg_addr_t wd;
		logic      wreg;
		word_t     word;    // ignored for mfhi/mflo, model supplies it
		exc_code_e exc;
	} row_t;

	// one predicted output, in acceptance order
	typedef struct {
		int        idx;
		word_t     word;
		exc_code_e exc;
		reg_addr_t wd;
		logic      wreg;
	} exp_t;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	aluop_e    in_op;
	word_t     in_a;
	word_t     in_b;
	reg_addr_t in_wd;
	logic      in_wreg;
	logic      in_ready;
	logic      out_valid;
	logic      out_ready;
	reg_addr_t out_wd;
	logic      out_wreg;
	word_t     out_wdata;
	exc_code_e out_exc;
	exc_cnt_t  exc_cnt;

	row_t      rows[$];
	exp_t      exp_q[$];
	word_t     model_hi;     // hi/lo as the stream should see them
	word_t     model_lo;
	int        n_checks;
	int        n_errors;
	int        n_ov;         // overflow rows sent so far
	int        held;         // results inside the dut
	int        full_seen;
	logic      bp_on;        // random out_ready when set
	integer    seed;

	tb_clk_gen tb_clk_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	ex_unit #(
		.DEPTH (DEPTH)
	) ex_unit_i (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.in_valid_i  (in_valid),
		.in_op_i     (in_op),
		.in_a_i      (in_a),
		.in_b_i      (in_b),
		.in_wd_i     (in_wd),
		.in_wreg_i   (in_wreg),
		.in_ready_o  (in_ready),
		.out_valid_o (out_valid),
		.out_ready_i (out_ready),
		.out_wd_o    (out_wd),
		.out_wreg_o  (out_wreg),
		.out_wdata_o (out_wdata),
		.out_exc_o   (out_exc),
		.exc_cnt_o   (exc_cnt)
	);

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic compare_word(input string what, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic verify_exc(input string what, input exc_code_e got, input exc_code_e exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic match_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input exc_cnt_t got, input exc_cnt_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic expect_flag(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	//////////////////////////////
	// stimulus table
	//////////////////////////////
	function automatic void add_row(input aluop_e op, input word_t a, input word_t b,
			input reg_addr_t wd, input logic wreg, input word_t word, input exc_code_e exc);
		row_t r;
		r.op   = op;
		r.a    = a;
		r.b    = b;
		r.wd   = wd;
		r.wreg = wreg;
		r.word = word;
		r.exc  = exc;
		rows.push_back(r);
	endfunction

	function automatic void build_table();
		// logic group, lui immediate sits in operand a
		add_row(OP_AND,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd1,  1'b1, 32'h00f0_1200, EC_NONE);
		add_row(OP_OR,    32'hf0f0_1234, 32'h0ff0_ff00, 5'd2,  1'b1, 32'hfff0_ff34, EC_NONE);
		add_row(OP_XOR,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd3,  1'b1, 32'hff00_ed34, EC_NONE);
		add_row(OP_NOR,   32'h1234_5678, 32'h0f0f_0f0f, 5'd4,  1'b1, 32'he0c0_a080, EC_NONE);
		add_row(OP_LUI,   32'hffff_8001, 32'h0000_0000, 5'd5,  1'b1, 32'h8001_0000, EC_NONE);
		// shifts, amount from b[4:0]
		add_row(OP_SLL,   32'h0000_0001, 32'd31,        5'd6,  1'b1, 32'h8000_0000, EC_NONE);
		add_row(OP_SLL,   32'h1234_5678, 32'h0000_0024, 5'd7,  1'b1, 32'h2345_6780, EC_NONE);
		add_row(OP_SRL,   32'h8000_0000, 32'd4,         5'd31, 1'b1, 32'h0800_0000, EC_NONE);
		add_row(OP_SRA,   32'h8000_0000, 32'd4,         5'd9,  1'b1, 32'hf800_0000, EC_NONE);
		add_row(OP_SRA,   32'hffff_ff00, 32'd8,         5'd10, 1'b0, 32'hffff_ffff, EC_NONE);
		// signed limits, trapping vs wrapping forms
		add_row(OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 5'd11, 1'b1, 32'h0000_0000, EC_OV);
		add_row(OP_ADDU,  32'h7fff_ffff, 32'h0000_0001, 5'd12, 1'b1, 32'h8000_0000, EC_NONE);
		add_row(OP_SUB,   32'h8000_0000, 32'h0000_0001, 5'd13, 1'b1, 32'h0000_0000, EC_OV);
		add_row(OP_SUBU,  32'h8000_0000, 32'h0000_0001, 5'd14, 1'b1, 32'h7fff_ffff, EC_NONE);
		add_row(OP_ADD,   32'hffff_ffff, 32'hffff_ffff, 5'd15, 1'b1, 32'hffff_fffe, EC_NONE);
		add_row(OP_SUB,   32'h0000_0005, 32'h0000_0007, 5'd16, 1'b1, 32'hffff_fffe, EC_NONE);
		add_row(OP_ADD,   32'h8000_0000, 32'h8000_0000, 5'd17, 1'b1, 32'h0000_0000, EC_OV);
		add_row(OP_SLT,   32'hffff_ffff, 32'h0000_0001, 5'd18, 1'b1, 32'h0000_0001, EC_NONE);
		add_row(OP_SLTU,  32'hffff_ffff, 32'h0000_0001, 5'd19, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_SLTU,  32'h0000_0001, 32'hffff_ffff, 5'd20, 1'b1, 32'h0000_0001, EC_NONE);
		// hi/lo traffic
		add_row(OP_MULT,  32'hffff_fffe, 32'h0000_0003, 5'd0,  1'b0, 32'h0000_0000, EC_NONE);
		add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 5'd21, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 5'd22, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MULTU, 32'hffff_fffe, 32'h0000_0003, 5'd0,  1'b0, 32'h0000_0000, EC_NONE);
		add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 5'd23, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 5'd24, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MTHI,  32'h1111_2222, 32'h0000_0000, 5'd0,  1'b0, 32'h0000_0000, EC_NONE);
		add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 5'd25, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 5'd26, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MTLO,  32'h3333_4444, 32'h0000_0000, 5'd0,  1'b0, 32'h0000_0000, EC_NONE);
		add_row(OP_MFHI,  32'h0000_0000, 32'h0000_0000, 5'd27, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_MFLO,  32'h0000_0000, 32'h0000_0000, 5'd28, 1'b1, 32'h0000_0000, EC_NONE);
		add_row(OP_NOP,   32'h0000_0000, 32'h0000_0000, 5'd0,  1'b0, 32'h0000_0000, EC_NONE);
	endfunction

	//////////////////////////////
	// reference model and driver
	//////////////////////////////
	task automatic predict_result(input row_t r, input int idx);
		exp_t   e;
		dword_t prod;
		e.idx  = idx;
		e.wd   = r.wd;
		e.exc  = r.exc;
		e.wreg = r.wreg && (r.exc == EC_NONE);    // overflow kills the write
		case (r.op)
			OP_MFHI: e.word = model_hi;
			OP_MFLO: e.word = model_lo;
			default: e.word = r.word;
		endcase
		case (r.op)
			OP_MULT: begin
				// sign extended operands, low 64 bits are the signed product
				prod = {{32{r.a[31]}}, r.a} * {{32{r.b[31]}}, r.b};
				{model_hi, model_lo} = prod;
			end
			OP_MULTU: begin
				prod = {32'h0, r.a} * {32'h0, r.b};
				{model_hi, model_lo} = prod;
			end
			OP_MTHI: model_hi = r.a;
			OP_MTLO: model_lo = r.a;
			default: ;
		endcase
		if (r.exc == EC_OV)
			n_ov++;
		exp_q.push_back(e);
	endtask

	task automatic wait_in_ready();
		int cyc;
		cyc = 0;
		@(negedge clk);
		while (!in_ready && cyc < WAIT_LIMIT) begin
			@(negedge clk);
			cyc++;
		end
		if (!in_ready)
			abort_on_timeout("in_ready_o");
	endtask

	// offer one row, it transfers on the edge after ready is seen
	task automatic send_row(input row_t r, input int idx);
		@(posedge clk);
		in_valid <= 1'b1;
		in_op    <= r.op;
		in_a     <= r.a;
		in_b     <= r.b;
		in_wd    <= r.wd;
		in_wreg  <= r.wreg;
		wait_in_ready();
		predict_result(r, idx);
	endtask

	task automatic run_table(input string label);
		int cyc;
		foreach (rows[i])
			send_row(rows[i], i);
		@(posedge clk);
		in_valid <= 1'b0;
		in_op    <= OP_NOP;
		cyc = 0;
		while (exp_q.size() != 0 && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		if (exp_q.size() != 0)
			abort_on_timeout({label, " results"});
		@(negedge clk);    // counter settles after the last drain
		check_count({label, " exc_cnt_o"}, exc_cnt, exc_cnt_t'(n_ov));
	endtask

	//////////////////////////////
	// sink side
	//////////////////////////////
	initial begin : sink_ready
		forever begin
			@(posedge clk);
			if (bp_on)
				out_ready <= (($random(seed) & 3) == 0);   // one cycle in four
			else
				out_ready <= 1'b1;
		end
	end

	// outputs compared in order where they are stable
	initial begin : consume
		exp_t e;
		forever begin
			@(negedge clk);
			if (rst_n && out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("ERROR %0d ns: a result came out with nothing outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					compare_word($sformatf("row %0d out_wdata_o", e.idx), out_wdata, e.word);
					verify_exc($sformatf("row %0d out_exc_o", e.idx), out_exc, e.exc);
					match_addr($sformatf("row %0d out_wd_o", e.idx), out_wd, e.wd);
					expect_flag($sformatf("row %0d out_wreg_o", e.idx), out_wreg, e.wreg);
				end
			end
		end
	end

	// fifo plus commit register full -> input must stall
	initial begin : occupancy
		forever begin
			@(negedge clk);
			if (held == DEPTH + 1) begin
				full_seen++;
				expect_flag("in_ready_o with all slots held", in_ready, 1'b0);
			end
			if (in_valid && in_ready)
				held++;
			if (out_valid && out_ready)
				held--;
		end
	end

	initial begin : main
		int cyc;
		seed      = 16269;
		bp_on     = 1'b0;
		n_checks  = 0;
		n_errors  = 0;
		n_ov      = 0;
		held      = 0;
		full_seen = 0;
		model_hi  = '0;
		model_lo  = '0;
		in_valid  = 1'b0;
		in_op     = OP_NOP;
		in_a      = '0;
		in_b      = '0;
		in_wd     = '0;
		in_wreg   = 1'b0;
		out_ready = 1'b1;
		build_table();

		cyc = 0;
		while (!rst_n && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		if (!rst_n)
			abort_on_timeout("reset release");
		@(negedge clk);
		expect_flag("out_valid_o after reset", out_valid, 1'b0);
		expect_flag("in_ready_o after reset", in_ready, 1'b1);
		check_count("exc_cnt_o after reset", exc_cnt, '0);

		run_table("free running");
		bp_on = 1'b1;
		run_table("back-pressure");
		if (full_seen == 0) begin
			n_errors++;
			$display("back-pressure never filled the buffer and the commit register");
		end

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
mips_isa_pkg.sv
ex_pipe_pkg.sv
ex_alu.sv
ex_result_fifo.sv
ex_commit.sv
ex_unit.sv
tb_clk_gen.sv
tb_ex_unit.sv

// File: Makefile
TOP := tb_ex_unit
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# pass only when the log holds the pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
